// File: sim/axi_sram_golden.txt
// op addr data strb resp rdata, all hex; op 1 write, 0 read, f ends the list
// resp 0 OKAY, 2 SLVERR; data and strb unused on reads, rdata unused on writes
1 00010 1234 3 0 0000
0 00010 0000 0 0 1234
1 00010 ffff 1 2 0000
1 00010 abcd 2 2 0000
1 00010 5555 0 2 0000
0 00010 0000 0 0 1234
1 00011 dead 3 2 0000
0 00011 0000 0 2 0000
0 00010 0000 0 0 1234
1 00000 a001 3 0 0000
1 00002 a002 3 0 0000
1 00004 a003 3 0 0000
1 00100 a004 3 0 0000
1 0fffe a005 3 0 0000
1 80000 a006 3 0 0000
1 ffffe a007 3 0 0000
1 4a6c2 a008 3 0 0000
0 ffffe 0000 0 0 a007
0 00002 0000 0 0 a002
0 4a6c2 0000 0 0 a008
0 00000 0000 0 0 a001
0 80000 0000 0 0 a006
0 00100 0000 0 0 a004
0 00004 0000 0 0 a003
0 0fffe 0000 0 0 a005
1 ffffd beef 3 2 0000
0 ffffe 0000 0 0 a007
f 00000 0000 0 0 0000

// File: list.f
logic/axi_lite_pkg.sv
logic/sram_pkg.sv
logic/sram_controller.sv
logic/axi_sram_controller.sv
logic/axi_sram_top.sv
sim/sram_chip_model.sv
sim/tb_axi_sram.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_axi_sram -f list.f

output=$(./obj_dir/Vtb_axi_sram)
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

// File: sim/tb_axi_sram.sv
module tb_axi_sram;

  import axi_lite_pkg::*;
  import sram_pkg::*;

  localparam string       GOLDEN_FILE    = "sim/axi_sram_golden.txt";
  localparam int          CLK_PERIOD     = 8;
  localparam int          MAX_DELAY      = 3;
  localparam int          MAX_TXNS       = 64;
  localparam int          CYCLES_PER_TXN = 40;
  localparam int unsigned SEED           = 32'h3d81_3e56;

  logic                       axi_clk;
  logic                       axi_resetn;
  logic [AXI_ADDR_WIDTH-1:0]  axi_awaddr;
  logic                       axi_awvalid;
  logic                       axi_awready;
  logic [AXI_DATA_WIDTH-1:0]  axi_wdata;
  logic [AXI_STRB_WIDTH-1:0]  axi_wstrb;
  logic                       axi_wvalid;
  logic                       axi_wready;
  logic [1:0]                 axi_bresp;
  logic                       axi_bvalid;
  logic                       axi_bready;
  logic [AXI_ADDR_WIDTH-1:0]  axi_araddr;
  logic                       axi_arvalid;
  logic                       axi_arready;
  logic [AXI_DATA_WIDTH-1:0]  axi_rdata;
  logic [1:0]                 axi_rresp;
  logic                       axi_rvalid;
  logic                       axi_rready;
  logic [SRAM_ADDR_WIDTH-1:0] sram_addr;
  wire  [SRAM_DATA_WIDTH-1:0] sram_data;
  logic                       sram_we_n;
  logic                       sram_oe_n;
  logic                       sram_ce_n;

  // Six words per transaction in the order op, addr, data, strb, resp, rdata
  logic [23:0] golden_mem [0:6*MAX_TXNS-1];
  int          txn_total;
  int          watchdog_cycles;
  int          error_count;

  axi_sram_top i_axi_sram_top (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .axi_awaddr  (axi_awaddr),
    .axi_awvalid (axi_awvalid),
    .axi_awready (axi_awready),
    .axi_wdata   (axi_wdata),
    .axi_wstrb   (axi_wstrb),
    .axi_wvalid  (axi_wvalid),
    .axi_wready  (axi_wready),
    .axi_bresp   (axi_bresp),
    .axi_bvalid  (axi_bvalid),
    .axi_bready  (axi_bready),
    .axi_araddr  (axi_araddr),
    .axi_arvalid (axi_arvalid),
    .axi_arready (axi_arready),
    .axi_rdata   (axi_rdata),
    .axi_rresp   (axi_rresp),
    .axi_rvalid  (axi_rvalid),
    .axi_rready  (axi_rready),
    .sram_addr   (sram_addr),
    .sram_data   (sram_data),
    .sram_we_n   (sram_we_n),
    .sram_oe_n   (sram_oe_n),
    .sram_ce_n   (sram_ce_n)
  );

  sram_chip_model i_sram_chip_model (
    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .sram_ce_n (sram_ce_n)
  );

  always #(CLK_PERIOD/2) axi_clk = ~axi_clk;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    error_count++;
    $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  task automatic load_golden();
    int fd;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the golden file %s", GOLDEN_FILE);
      error_count++;
      return;
    end
    $fclose(fd);
    $readmemh(GOLDEN_FILE, golden_mem);
    // List ends at an op of f
    while (txn_total < MAX_TXNS && golden_mem[6*txn_total] != 24'h00000f) begin
      txn_total++;
    end
    if (txn_total == 0 || txn_total == MAX_TXNS) begin
      $display("Golden file holds no transactions or lacks its end marker");
      error_count++;
    end
  endtask

  // Chip pins at one falling edge while an access may be running
  task automatic check_sram_pins(input logic [AXI_ADDR_WIDTH-1:0] addr, input logic write,
                                 output logic active);
    active = !sram_ce_n;
    if (active) begin
      if (sram_addr !== addr[AXI_ADDR_WIDTH-1:1]) begin
        report_mismatch("sram_addr", 32'(sram_addr), 32'(addr[AXI_ADDR_WIDTH-1:1]));
      end
      if (sram_we_n !== !write) report_mismatch("sram_we_n", 32'(sram_we_n), 32'(!write));
      if (sram_oe_n !== write) report_mismatch("sram_oe_n", 32'(sram_oe_n), 32'(write));
    end
  endtask

  // Starts on a falling edge and returns on one with the DUT idle
  task automatic write_and_check(input logic [AXI_ADDR_WIDTH-1:0] addr,
                                 input logic [AXI_DATA_WIDTH-1:0] data,
                                 input logic [AXI_STRB_WIDTH-1:0] strb,
                                 input logic [1:0] exp_resp);
    int         delay;
    logic [1:0] held_resp;
    logic       active;
    logic       touched;
    axi_awaddr  = addr;
    axi_wdata   = data;
    axi_wstrb   = strb;
    axi_awvalid = 1'b1;
    axi_wvalid  = 1'b1;
    touched     = 1'b0;
    while (!axi_awready) begin
      @(negedge axi_clk);
      check_sram_pins(addr, 1'b1, active);
      touched = touched || active;
    end
    if (touched != (exp_resp == RESP_OKAY)) begin
      $display("SRAM chip enable activity does not match the expected write response");
      error_count++;
    end
    if (axi_wready !== 1'b1) report_mismatch("axi_wready", 32'(axi_wready), 32'd1);
    @(negedge axi_clk);
    axi_awvalid = 1'b0;
    axi_wvalid  = 1'b0;
    while (!axi_bvalid) @(negedge axi_clk);
    if (axi_bresp !== exp_resp) report_mismatch("axi_bresp", 32'(axi_bresp), 32'(exp_resp));
    held_resp = axi_bresp;
    delay = $urandom_range(MAX_DELAY, 0);
    // B channel must hold under back-pressure
    repeat (delay) begin
      @(negedge axi_clk);
      if (axi_bvalid !== 1'b1) report_mismatch("axi_bvalid", 32'(axi_bvalid), 32'd1);
      if (axi_bresp !== held_resp) begin
        report_mismatch("axi_bresp", 32'(axi_bresp), 32'(held_resp));
      end
    end
    axi_bready = 1'b1;
    @(negedge axi_clk);
    axi_bready = 1'b0;
  endtask

  task automatic read_and_check(input logic [AXI_ADDR_WIDTH-1:0] addr,
                                input logic [1:0] exp_resp,
                                input logic [AXI_DATA_WIDTH-1:0] exp_data);
    int                        delay;
    logic [1:0]                held_resp;
    logic [AXI_DATA_WIDTH-1:0] held_data;
    logic                      active;
    logic                      touched;
    axi_araddr  = addr;
    axi_arvalid = 1'b1;
    touched     = 1'b0;
    while (!axi_arready) begin
      @(negedge axi_clk);
      check_sram_pins(addr, 1'b0, active);
      touched = touched || active;
    end
    if (touched != (exp_resp == RESP_OKAY)) begin
      $display("SRAM chip enable activity does not match the expected read response");
      error_count++;
    end
    @(negedge axi_clk);
    axi_arvalid = 1'b0;
    while (!axi_rvalid) @(negedge axi_clk);
    if (axi_rresp !== exp_resp) report_mismatch("axi_rresp", 32'(axi_rresp), 32'(exp_resp));
    if (axi_rdata !== exp_data) report_mismatch("axi_rdata", 32'(axi_rdata), 32'(exp_data));
    held_resp = axi_rresp;
    held_data = axi_rdata;
    delay = $urandom_range(MAX_DELAY, 0);
    repeat (delay) begin
      @(negedge axi_clk);
      if (axi_rvalid !== 1'b1) report_mismatch("axi_rvalid", 32'(axi_rvalid), 32'd1);
      if (axi_rresp !== held_resp) begin
        report_mismatch("axi_rresp", 32'(axi_rresp), 32'(held_resp));
      end
      if (axi_rdata !== held_data) begin
        report_mismatch("axi_rdata", 32'(axi_rdata), 32'(held_data));
      end
    end
    axi_rready = 1'b1;
    @(negedge axi_clk);
    axi_rready = 1'b0;
  endtask

  initial begin
    int          base;
    logic [23:0] op;
    axi_clk     = 1'b0;
    axi_resetn  = 1'b0;
    axi_awaddr  = '0;
    axi_awvalid = 1'b0;
    axi_wdata   = '0;
    axi_wstrb   = '0;
    axi_wvalid  = 1'b0;
    axi_bready  = 1'b0;
    axi_araddr  = '0;
    axi_arvalid = 1'b0;
    axi_rready  = 1'b0;
    txn_total   = 0;
    error_count = 0;
    void'($urandom(SEED));
    load_golden();
    watchdog_cycles = (txn_total + 1) * CYCLES_PER_TXN;

    repeat (2) @(posedge axi_clk);
    @(negedge axi_clk);
    axi_resetn = 1'b1;

    // Nothing handshakes or touches the chip before the first request
    repeat (3) begin
      @(negedge axi_clk);
      if (axi_awready || axi_wready || axi_bvalid || axi_arready || axi_rvalid) begin
        $display("A ready or valid output went high after reset with nothing pending");
        error_count++;
      end
      if (!(sram_ce_n && sram_we_n && sram_oe_n)) begin
        $display("An SRAM strobe was active after reset with nothing pending");
        error_count++;
      end
    end

    for (int i = 0; i < txn_total; i++) begin
      base = 6 * i;
      op   = golden_mem[base];
      if (op == 24'd1) begin
        write_and_check(golden_mem[base+1][AXI_ADDR_WIDTH-1:0],
                        golden_mem[base+2][AXI_DATA_WIDTH-1:0],
                        golden_mem[base+3][AXI_STRB_WIDTH-1:0], golden_mem[base+4][1:0]);
      end else if (op == 24'd0) begin
        read_and_check(golden_mem[base+1][AXI_ADDR_WIDTH-1:0], golden_mem[base+4][1:0],
                       golden_mem[base+5][AXI_DATA_WIDTH-1:0]);
      end else begin
        $display("Golden line %0d has an unknown operation code", i);
        error_count++;
      end
    end

    $display("Transactions: %0d, errors: %0d", txn_total, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog sized from the golden line count
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge axi_clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding",
             watchdog_cycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: sim/sram_chip_model.sv
module sram_chip_model (
  input  logic [sram_pkg::SRAM_ADDR_WIDTH-1:0] sram_addr,
  inout  wire  [sram_pkg::SRAM_DATA_WIDTH-1:0] sram_data,
  input  logic                                 sram_we_n,
  input  logic                                 sram_oe_n,
  input  logic                                 sram_ce_n
);

  import sram_pkg::*;

  logic [SRAM_DATA_WIDTH-1:0] mem [0:(2**SRAM_ADDR_WIDTH)-1];

  // Level-sensitive store, the word follows the bus while ce_n and we_n are low
  always begin
    @(sram_ce_n or sram_we_n or sram_addr or sram_data);
    if (!sram_ce_n && !sram_we_n) begin
      mem[sram_addr] = sram_data;
    end
  end

  // Read drive only with oe_n low and no write in progress
  assign sram_data = (!sram_ce_n && !sram_oe_n && sram_we_n) ? mem[sram_addr] : 'z;

endmodule

// File: logic/axi_sram_top.sv
module axi_sram_top (
  input  logic                                  axi_clk,
  input  logic                                  axi_resetn,
  input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] axi_awaddr,
  input  logic                                  axi_awvalid,
  output logic                                  axi_awready,
  input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] axi_wdata,
  input  logic [axi_lite_pkg::AXI_STRB_WIDTH-1:0] axi_wstrb,
  input  logic                                  axi_wvalid,
  output logic                                  axi_wready,
  output logic [1:0]                            axi_bresp,
  output logic                                  axi_bvalid,
  input  logic                                  axi_bready,
  input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] axi_araddr,
  input  logic                                  axi_arvalid,
  output logic                                  axi_arready,
  output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] axi_rdata,
  output logic [1:0]                            axi_rresp,
  output logic                                  axi_rvalid,
  input  logic                                  axi_rready,
  output logic [sram_pkg::SRAM_ADDR_WIDTH-1:0]  sram_addr,
  inout  wire  [sram_pkg::SRAM_DATA_WIDTH-1:0]  sram_data,
  output logic                                  sram_we_n,
  output logic                                  sram_oe_n,
  output logic                                  sram_ce_n
);

  axi_sram_controller i_axi_sram_controller (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .axi_awaddr  (axi_awaddr),
    .axi_awvalid (axi_awvalid),
    .axi_awready (axi_awready),
    .axi_wdata   (axi_wdata),
    .axi_wstrb   (axi_wstrb),
    .axi_wvalid  (axi_wvalid),
    .axi_wready  (axi_wready),
    .axi_bresp   (axi_bresp),
    .axi_bvalid  (axi_bvalid),
    .axi_bready  (axi_bready),
    .axi_araddr  (axi_araddr),
    .axi_arvalid (axi_arvalid),
    .axi_arready (axi_arready),
    .axi_rdata   (axi_rdata),
    .axi_rresp   (axi_rresp),
    .axi_rvalid  (axi_rvalid),
    .axi_rready  (axi_rready),
    .sram_addr   (sram_addr),
    .sram_data   (sram_data),
    .sram_we_n   (sram_we_n),
    .sram_oe_n   (sram_oe_n),
    .sram_ce_n   (sram_ce_n)
  );

endmodule

// File: logic/axi_sram_controller.sv
module axi_sram_controller (
  input  logic                                  axi_clk,
  input  logic                                  axi_resetn,

  // Write address
  input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] axi_awaddr,
  input  logic                                  axi_awvalid,
  output logic                                  axi_awready,

  // Write data
  input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] axi_wdata,
  input  logic [axi_lite_pkg::AXI_STRB_WIDTH-1:0] axi_wstrb,
  input  logic                                  axi_wvalid,
  output logic                                  axi_wready,

  // Write response
  output logic [1:0]                            axi_bresp,
  output logic                                  axi_bvalid,
  input  logic                                  axi_bready,

  // Read address
  input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] axi_araddr,
  input  logic                                  axi_arvalid,
  output logic                                  axi_arready,

  // Read data
  output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] axi_rdata,
  output logic [1:0]                            axi_rresp,
  output logic                                  axi_rvalid,
  input  logic                                  axi_rready,

  // SRAM pins
  output logic [sram_pkg::SRAM_ADDR_WIDTH-1:0]  sram_addr,
  inout  wire  [sram_pkg::SRAM_DATA_WIDTH-1:0]  sram_data,
  output logic                                  sram_we_n,
  output logic                                  sram_oe_n,
  output logic                                  sram_ce_n
);

  import axi_lite_pkg::*;
  import sram_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_ACCESS,
    ST_WR_RESP,
    ST_RD_ACCESS,
    ST_RD_RESP
  } state_t;

  state_t                     state;
  logic                       err_q;
  logic [1:0]                 resp_q;
  logic [AXI_DATA_WIDTH-1:0]  rdata_q;
  logic                       access_done;

  // Internal link to the pin controller
  logic                       sram_req;
  logic                       sram_write;
  logic [SRAM_ADDR_WIDTH-1:0] sram_word_addr;
  logic [SRAM_DATA_WIDTH-1:0] sram_wdata;
  logic                       sram_ready;
  logic [SRAM_DATA_WIDTH-1:0] sram_rdata;

  sram_controller i_sram_controller (
    .axi_clk        (axi_clk),
    .axi_resetn     (axi_resetn),
    .sram_req       (sram_req),
    .sram_write     (sram_write),
    .sram_word_addr (sram_word_addr),
    .sram_wdata     (sram_wdata),
    .sram_ready     (sram_ready),
    .sram_rdata     (sram_rdata),
    .sram_addr      (sram_addr),
    .sram_data      (sram_data),
    .sram_we_n      (sram_we_n),
    .sram_oe_n      (sram_oe_n),
    .sram_ce_n      (sram_ce_n)
  );

  // An erroring access finishes in its first cycle, a good one on sram_ready
  assign access_done = err_q || sram_ready;

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      state <= ST_IDLE;
      err_q <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Writes win when both are pending
          if (axi_awvalid && axi_wvalid) begin
            state <= ST_WR_ACCESS;
            err_q <= axi_awaddr[0] || !(&axi_wstrb);
          end else if (axi_arvalid) begin
            state <= ST_RD_ACCESS;
            err_q <= axi_araddr[0];
          end
        end

        ST_WR_ACCESS: begin
          if (access_done) begin
            state <= ST_WR_RESP;
          end
        end

        ST_WR_RESP: begin
          if (axi_bready) begin
            state <= ST_IDLE;
          end
        end

        ST_RD_ACCESS: begin
          if (access_done) begin
            state <= ST_RD_RESP;
          end
        end

        ST_RD_RESP: begin
          if (axi_rready) begin
            state <= ST_IDLE;
          end
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Response held steady through back-pressure
  always_ff @(posedge axi_clk) begin
    if ((state == ST_WR_ACCESS || state == ST_RD_ACCESS) && access_done) begin
      resp_q <= err_q ? RESP_SLVERR : RESP_OKAY;
    end
    if (state == ST_RD_ACCESS && access_done) begin
      rdata_q <= err_q ? '0 : sram_rdata;
    end
  end

  // Request only for judged-good accesses; addresses drop byte bit 0
  assign sram_req       = (state == ST_WR_ACCESS || state == ST_RD_ACCESS) && !err_q;
  assign sram_write     = (state == ST_WR_ACCESS);
  assign sram_word_addr = sram_write ? axi_awaddr[AXI_ADDR_WIDTH-1:1]
                                     : axi_araddr[AXI_ADDR_WIDTH-1:1];
  assign sram_wdata     = axi_wdata;

  assign axi_awready = (state == ST_WR_ACCESS) && access_done;
  assign axi_wready  = (state == ST_WR_ACCESS) && access_done;
  assign axi_bvalid  = (state == ST_WR_RESP);
  assign axi_bresp   = resp_q;

  assign axi_arready = (state == ST_RD_ACCESS) && access_done;
  assign axi_rvalid  = (state == ST_RD_RESP);
  assign axi_rresp   = resp_q;
  assign axi_rdata   = rdata_q;

endmodule

// File: logic/sram_controller.sv
module sram_controller (
  input  logic                                 axi_clk,
  input  logic                                 axi_resetn,

  // Request side, held by the requester until sram_ready
  input  logic                                 sram_req,
  input  logic                                 sram_write,
  input  logic [sram_pkg::SRAM_ADDR_WIDTH-1:0] sram_word_addr,
  input  logic [sram_pkg::SRAM_DATA_WIDTH-1:0] sram_wdata,
  output logic                                 sram_ready,
  output logic [sram_pkg::SRAM_DATA_WIDTH-1:0] sram_rdata,

  // Chip pins
  output logic [sram_pkg::SRAM_ADDR_WIDTH-1:0] sram_addr,
  inout  wire  [sram_pkg::SRAM_DATA_WIDTH-1:0] sram_data,
  output logic                                 sram_we_n,
  output logic                                 sram_oe_n,
  output logic                                 sram_ce_n
);

  import sram_pkg::*;

  // Counter only has to reach the longer of the two access lengths
  localparam int unsigned WAIT_MAX =
    (SRAM_WRITE_CYCLES > SRAM_READ_CYCLES) ? SRAM_WRITE_CYCLES : SRAM_READ_CYCLES;
  localparam int unsigned CNT_WIDTH = (WAIT_MAX > 1) ? $clog2(WAIT_MAX) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ,
    ST_DONE
  } state_t;

  state_t                     state;
  logic [CNT_WIDTH-1:0]       wait_cnt;
  logic [SRAM_DATA_WIDTH-1:0] wdata_q;
  logic                       last_cycle;

  // Final wait cycle of the access in progress
  always_comb begin
    case (state)
      ST_WRITE: last_cycle = (wait_cnt == CNT_WIDTH'(SRAM_WRITE_CYCLES - 1));
      ST_READ:  last_cycle = (wait_cnt == CNT_WIDTH'(SRAM_READ_CYCLES - 1));
      default:  last_cycle = 1'b0;
    endcase
  end

  // Access sequencing and the active-low strobes
  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      state     <= ST_IDLE;
      wait_cnt  <= '0;
      sram_ce_n <= 1'b1;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
    end else begin
      case (state)
        ST_IDLE: begin
          if (sram_req) begin
            state     <= sram_write ? ST_WRITE : ST_READ;
            wait_cnt  <= '0;
            sram_ce_n <= 1'b0;
            sram_we_n <= !sram_write;
            sram_oe_n <= sram_write;
          end
        end

        ST_WRITE, ST_READ: begin
          if (last_cycle) begin
            state     <= ST_DONE;
            sram_ce_n <= 1'b1;
            sram_we_n <= 1'b1;
            sram_oe_n <= 1'b1;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end

        // Ready cycle; req is still high here, so it must not restart
        ST_DONE: begin
          state <= ST_IDLE;
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Address and write data captured once per access
  always_ff @(posedge axi_clk) begin
    if (state == ST_IDLE && sram_req) begin
      sram_addr <= sram_word_addr;
      wdata_q   <= sram_wdata;
    end
  end

  // Bus sampled at the end of the last oe_n cycle
  always_ff @(posedge axi_clk) begin
    if (state == ST_READ && last_cycle) begin
      sram_rdata <= sram_data;
    end
  end

  // Drive the shared bus only while we_n is low
  assign sram_data = sram_we_n ? 'z : wdata_q;

  assign sram_ready = (state == ST_DONE);

endmodule

// File: logic/sram_pkg.sv
package sram_pkg;

  // Word width of the external chip
  localparam int unsigned SRAM_DATA_WIDTH = 16;

  // Word address, one bit narrower than the byte address
  localparam int unsigned SRAM_ADDR_WIDTH = 19;

  // Cycles with ce_n and we_n held low for one write
  localparam int unsigned SRAM_WRITE_CYCLES = 2;

  // Cycles with oe_n low before the bus is sampled
  localparam int unsigned SRAM_READ_CYCLES = 2;

endpackage

// File: logic/axi_lite_pkg.sv
package axi_lite_pkg;

  // Byte address width seen on the AXI-Lite side
  localparam int unsigned AXI_ADDR_WIDTH = 20;

  // One 16-bit word per data beat
  localparam int unsigned AXI_DATA_WIDTH = 16;

  // One strobe per byte lane
  localparam int unsigned AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

  // Response codes on B and R
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
